/* mm_ram_macros.svh */
/*
 * Memory map and constants of the test memory
 * region bases and lengths, boot-loop word, pass value and timer irq id
 */
`ifndef MM_RAM_MACROS_SVH
`define MM_RAM_MACROS_SVH

// ram mirrored at zero and at the sram base
`define MM_SRAM_BASE      32'h1C00_0000
`define MM_SRAM_LEN       32'h0000_4000

// boot rom region whose reads return the boot-loop word
`define MM_ROM_BASE       32'h1A00_0000
`define MM_ROM_LEN        32'h0000_2000

// test status register
`define MM_CTRL_BASE      32'h1A10_4000
`define MM_CTRL_LEN       32'h0000_1000

// timer region with the irq mask at offset 0 and the count at offset 4
`define MM_TIMER_BASE     32'h1A10_B000
`define MM_TIMER_LEN      32'h0000_1000

// jal x0, 0 keeps the core spinning until jtag takes over
`define MM_BOOT_LOOP_WORD 32'h0000_006F
`define MM_PASS_VALUE     32'h0000_F00D
`define MM_TIMER_IRQ_ID   5'd3

// byte address width of the ram
`define MM_RAM_AW         14

`endif

/* hw/mm_ram_pkg.sv */
/*
 * Shared types of the test memory
 * bus master and read source encodings, address regions and the decoder
 */
`include "mm_ram_macros.svh"

package mm_ram_pkg;

    typedef enum logic [1:0] {
        MASTER_NONE,
        MASTER_INSTR,
        MASTER_DATA,
        MASTER_SB
    } bus_master_e;

    typedef enum logic [1:0] {
        SRC_NONE,
        SRC_RAM,
        SRC_ROM
    } rd_src_e;

    typedef enum logic [2:0] {
        REGION_RAM,
        REGION_ROM,
        REGION_CTRL,
        REGION_TIMER,
        REGION_UNMAP
    } region_e;

    // ram answers at both mirrors, anything outside the known regions is unmapped
    function automatic region_e decode_region(input logic [31:0] addr);
        region_e region;
        region = REGION_UNMAP;
        if ((addr >= `MM_SRAM_BASE && addr < `MM_SRAM_BASE + `MM_SRAM_LEN) ||
            addr < `MM_SRAM_LEN) begin
            region = REGION_RAM;
        end else if (addr >= `MM_ROM_BASE && addr < `MM_ROM_BASE + `MM_ROM_LEN) begin
            region = REGION_ROM;
        end else if (addr >= `MM_CTRL_BASE && addr < `MM_CTRL_BASE + `MM_CTRL_LEN) begin
            region = REGION_CTRL;
        end else if (addr >= `MM_TIMER_BASE && addr < `MM_TIMER_BASE + `MM_TIMER_LEN) begin
            region = REGION_TIMER;
        end
        return region;
    endfunction

endpackage

/* hw/bus_arbiter.sv */
/*
 * Fixed-priority bus arbiter
 * grants one of system bus, data and instruction per cycle, decodes the
 * winner's address and routes it to the ram or the peripheral strobes
 */
`timescale 1ns/1ps
`include "mm_ram_macros.svh"

module bus_arbiter
    import mm_ram_pkg::*;
(
    input  logic                   instr_req_i,
    input  logic [31:0]            instr_addr_i,

    input  logic                   data_req_i,
    input  logic [31:0]            data_addr_i,
    input  logic                   data_we_i,
    input  logic [3:0]             data_be_i,
    input  logic [31:0]            data_wdata_i,

    input  logic                   sb_req_i,
    input  logic [31:0]            sb_addr_i,
    input  logic                   sb_we_i,
    input  logic [3:0]             sb_be_i,
    input  logic [31:0]            sb_wdata_i,

    output logic                   instr_gnt_o,
    output logic                   data_gnt_o,
    output logic                   sb_gnt_o,

    output logic                   ram_req_o,
    output logic                   ram_we_o,
    output logic [3:0]             ram_be_o,
    output logic [`MM_RAM_AW-3:0]  ram_addr_o,
    output logic [31:0]            ram_wdata_o,

    output logic                   ctrl_we_o,
    output logic [31:0]            ctrl_wdata_o,
    output logic                   timer_mask_we_o,
    output logic                   timer_cnt_we_o,
    output logic [31:0]            timer_wdata_o,

    output bus_master_e            gnt_master_o,
    output rd_src_e                rd_src_o
);

    logic [31:0] win_addr;
    logic        win_we;
    logic [3:0]  win_be;
    logic [31:0] win_wdata;
    logic [31:0] timer_off;
    region_e     win_region;

    // system bus first, then core data, then instruction fetch
    always_comb begin
        sb_gnt_o    = sb_req_i;
        data_gnt_o  = data_req_i && !sb_req_i;
        instr_gnt_o = instr_req_i && !sb_req_i && !data_req_i;
    end

    // pick the request fields of the winner
    always_comb begin
        gnt_master_o = MASTER_NONE;
        win_addr     = '0;
        win_we       = 1'b0;
        win_be       = '0;
        win_wdata    = '0;
        if (sb_req_i) begin
            gnt_master_o = MASTER_SB;
            win_addr     = sb_addr_i;
            win_we       = sb_we_i;
            win_be       = sb_be_i;
            win_wdata    = sb_wdata_i;
        end else if (data_req_i) begin
            gnt_master_o = MASTER_DATA;
            win_addr     = data_addr_i;
            win_we       = data_we_i;
            win_be       = data_be_i;
            win_wdata    = data_wdata_i;
        end else if (instr_req_i) begin
            // fetches are full-word reads
            gnt_master_o = MASTER_INSTR;
            win_addr     = instr_addr_i;
            win_be       = 4'b1111;
        end
    end

    assign win_region = decode_region(win_addr);
    assign timer_off  = win_addr - `MM_TIMER_BASE;

    // payload goes out unconditionally, the strobes qualify it
    assign ram_addr_o    = win_addr[`MM_RAM_AW-1:2];
    assign ram_wdata_o   = win_wdata;
    assign ctrl_wdata_o  = data_wdata_i;
    assign timer_wdata_o = win_wdata;

    always_comb begin
        ram_req_o       = 1'b0;
        ram_we_o        = 1'b0;
        ram_be_o        = '0;
        ctrl_we_o       = 1'b0;
        timer_mask_we_o = 1'b0;
        timer_cnt_we_o  = 1'b0;
        rd_src_o        = SRC_NONE;

        if (gnt_master_o != MASTER_NONE) begin
            case (win_region)
                REGION_RAM: begin
                    ram_req_o = 1'b1;
                    ram_we_o  = win_we;
                    ram_be_o  = win_be;
                    if (!win_we) rd_src_o = SRC_RAM;
                end
                REGION_ROM: begin
                    // writes are granted and dropped
                    if (!win_we) rd_src_o = SRC_ROM;
                end
                REGION_CTRL: begin
                    // only the core reports test status
                    ctrl_we_o = win_we && (gnt_master_o == MASTER_DATA);
                end
                REGION_TIMER: begin
                    timer_mask_we_o = win_we && (timer_off[31:2] == 30'd0);
                    timer_cnt_we_o  = win_we && (timer_off[31:2] == 30'd1);
                end
                default: begin
                end
            endcase
        end
    end

endmodule

/* hw/word_ram.sv */
/*
 * Single-port word RAM
 * per-byte write enables, read data registered one cycle after the request
 */
`timescale 1ns/1ps
`include "mm_ram_macros.svh"

module word_ram #(
    parameter int unsigned ADDR_WIDTH = `MM_RAM_AW
) (
    input  logic                  clk_i,
    input  logic                  req_i,
    input  logic                  we_i,
    input  logic [3:0]            be_i,
    input  logic [ADDR_WIDTH-3:0] addr_i,
    input  logic [31:0]           wdata_i,
    output logic [31:0]           rdata_o
);

    localparam int unsigned DEPTH = 2 ** (ADDR_WIDTH - 2);

    logic [31:0] mem [DEPTH];

    // byte lanes are written independently
    always_ff @(posedge clk_i) begin
        if (req_i && we_i) begin
            for (int i = 0; i < 4; i++) begin
                if (be_i[i]) begin
                    mem[addr_i][8*i +: 8] <= wdata_i[8*i +: 8];
                end
            end
        end
    end

    // read port, holds its value between reads
    always_ff @(posedge clk_i) begin
        if (req_i && !we_i) begin
            rdata_o <= mem[addr_i];
        end
    end

endmodule

/* hw/periph_regs.sv */
/*
 * Pseudo peripherals of the test memory
 * test pass/fail pulses and a countdown timer with masked interrupt
 */
`timescale 1ns/1ps
`include "mm_ram_macros.svh"

module periph_regs (
    input  logic        clk_i,
    input  logic        rst_ni,

    input  logic        ctrl_we_i,
    input  logic [31:0] ctrl_wdata_i,

    input  logic        timer_mask_we_i,
    input  logic        timer_cnt_we_i,
    input  logic [31:0] timer_wdata_i,

    input  logic        irq_ack_i,
    input  logic [4:0]  irq_id_i,

    output logic        irq_o,
    output logic        tests_passed_o,
    output logic        tests_failed_o
);

    logic [31:0] timer_mask_q;
    logic [31:0] timer_cnt_q;
    logic        irq_q;
    logic        ack_match;

    assign ack_match = irq_ack_i && (irq_id_i == `MM_TIMER_IRQ_ID);
    assign irq_o     = irq_q;

    // status pulse lines up with the write's rvalid
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            tests_passed_o <= 1'b0;
            tests_failed_o <= 1'b0;
        end else begin
            tests_passed_o <= ctrl_we_i && (ctrl_wdata_i == `MM_PASS_VALUE);
            tests_failed_o <= ctrl_we_i && (ctrl_wdata_i != `MM_PASS_VALUE);
        end
    end

    // countdown pauses in any cycle that writes a timer register
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            timer_mask_q <= '0;
            timer_cnt_q  <= '0;
        end else if (timer_mask_we_i) begin
            timer_mask_q <= timer_wdata_i;
        end else if (timer_cnt_we_i) begin
            timer_cnt_q <= timer_wdata_i;
        end else if (timer_cnt_q != '0) begin
            timer_cnt_q <= timer_cnt_q - 32'd1;
        end
    end

    // irq fires on the 1 -> 0 step when its mask bit is set
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            irq_q <= 1'b0;
        end else if (!timer_mask_we_i && !timer_cnt_we_i && timer_cnt_q == 32'd1 &&
                     timer_mask_q[`MM_TIMER_IRQ_ID]) begin
            irq_q <= 1'b1;
        end else if (ack_match) begin
            irq_q <= 1'b0;
        end
    end

endmodule

/* hw/resp_mux.sv */
/*
 * Response path of the test memory
 * remembers who was granted and from where it reads, then returns
 * rvalid and rdata to that master one cycle later
 */
`timescale 1ns/1ps
`include "mm_ram_macros.svh"

module resp_mux
    import mm_ram_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_ni,

    input  bus_master_e gnt_master_i,
    input  rd_src_e     rd_src_i,
    input  logic [31:0] ram_rdata_i,

    output logic        instr_rvalid_o,
    output logic [31:0] instr_rdata_o,
    output logic        data_rvalid_o,
    output logic [31:0] data_rdata_o,
    output logic        sb_rvalid_o,
    output logic [31:0] sb_rdata_o
);

    bus_master_e gnt_master_q;
    rd_src_e     rd_src_q;
    logic [31:0] resp_rdata;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            gnt_master_q <= MASTER_NONE;
            rd_src_q     <= SRC_NONE;
        end else begin
            gnt_master_q <= gnt_master_i;
            rd_src_q     <= rd_src_i;
        end
    end

    // writes and unmapped reads come back as zero
    always_comb begin
        case (rd_src_q)
            SRC_RAM: resp_rdata = ram_rdata_i;
            SRC_ROM: resp_rdata = `MM_BOOT_LOOP_WORD;
            default: resp_rdata = '0;
        endcase
    end

    assign instr_rvalid_o = (gnt_master_q == MASTER_INSTR);
    assign data_rvalid_o  = (gnt_master_q == MASTER_DATA);
    assign sb_rvalid_o    = (gnt_master_q == MASTER_SB);

    // only the master being answered sees data
    assign instr_rdata_o = instr_rvalid_o ? resp_rdata : '0;
    assign data_rdata_o  = data_rvalid_o  ? resp_rdata : '0;
    assign sb_rdata_o    = sb_rvalid_o    ? resp_rdata : '0;

endmodule

/* hw/mm_ram_top.sv */
/*
 * Memory-mapped test memory for a small RISC-V core
 * instruction, data and system bus masters share one word RAM,
 * a boot-loop ROM region, a test status register and a timer
 */
`timescale 1ns/1ps
`include "mm_ram_macros.svh"

module mm_ram_top
    import mm_ram_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_ni,

    input  logic        instr_req_i,
    input  logic [31:0] instr_addr_i,
    output logic        instr_gnt_o,
    output logic        instr_rvalid_o,
    output logic [31:0] instr_rdata_o,

    input  logic        data_req_i,
    input  logic [31:0] data_addr_i,
    input  logic        data_we_i,
    input  logic [3:0]  data_be_i,
    input  logic [31:0] data_wdata_i,
    output logic        data_gnt_o,
    output logic        data_rvalid_o,
    output logic [31:0] data_rdata_o,

    input  logic        sb_req_i,
    input  logic [31:0] sb_addr_i,
    input  logic        sb_we_i,
    input  logic [3:0]  sb_be_i,
    input  logic [31:0] sb_wdata_i,
    output logic        sb_gnt_o,
    output logic        sb_rvalid_o,
    output logic [31:0] sb_rdata_o,

    input  logic        irq_ack_i,
    input  logic [4:0]  irq_id_i,
    output logic        irq_o,
    output logic [4:0]  irq_id_o,

    output logic        tests_passed_o,
    output logic        tests_failed_o
);

    logic                  ram_req;
    logic                  ram_we;
    logic [3:0]            ram_be;
    logic [`MM_RAM_AW-3:0] ram_addr;
    logic [31:0]           ram_wdata;
    logic [31:0]           ram_rdata;

    logic                  ctrl_we;
    logic [31:0]           ctrl_wdata;
    logic                  timer_mask_we;
    logic                  timer_cnt_we;
    logic [31:0]           timer_wdata;

    bus_master_e           gnt_master;
    rd_src_e               rd_src;

    // the timer is the only interrupt source
    assign irq_id_o = `MM_TIMER_IRQ_ID;

    bus_arbiter u_arbiter (
        .instr_req_i     (instr_req_i),
        .instr_addr_i    (instr_addr_i),
        .data_req_i      (data_req_i),
        .data_addr_i     (data_addr_i),
        .data_we_i       (data_we_i),
        .data_be_i       (data_be_i),
        .data_wdata_i    (data_wdata_i),
        .sb_req_i        (sb_req_i),
        .sb_addr_i       (sb_addr_i),
        .sb_we_i         (sb_we_i),
        .sb_be_i         (sb_be_i),
        .sb_wdata_i      (sb_wdata_i),
        .instr_gnt_o     (instr_gnt_o),
        .data_gnt_o      (data_gnt_o),
        .sb_gnt_o        (sb_gnt_o),
        .ram_req_o       (ram_req),
        .ram_we_o        (ram_we),
        .ram_be_o        (ram_be),
        .ram_addr_o      (ram_addr),
        .ram_wdata_o     (ram_wdata),
        .ctrl_we_o       (ctrl_we),
        .ctrl_wdata_o    (ctrl_wdata),
        .timer_mask_we_o (timer_mask_we),
        .timer_cnt_we_o  (timer_cnt_we),
        .timer_wdata_o   (timer_wdata),
        .gnt_master_o    (gnt_master),
        .rd_src_o        (rd_src)
    );

    word_ram #(
        .ADDR_WIDTH (`MM_RAM_AW)
    ) u_ram (
        .clk_i   (clk_i),
        .req_i   (ram_req),
        .we_i    (ram_we),
        .be_i    (ram_be),
        .addr_i  (ram_addr),
        .wdata_i (ram_wdata),
        .rdata_o (ram_rdata)
    );

    periph_regs u_periph (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .ctrl_we_i       (ctrl_we),
        .ctrl_wdata_i    (ctrl_wdata),
        .timer_mask_we_i (timer_mask_we),
        .timer_cnt_we_i  (timer_cnt_we),
        .timer_wdata_i   (timer_wdata),
        .irq_ack_i       (irq_ack_i),
        .irq_id_i        (irq_id_i),
        .irq_o           (irq_o),
        .tests_passed_o  (tests_passed_o),
        .tests_failed_o  (tests_failed_o)
    );

    resp_mux u_resp (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .gnt_master_i   (gnt_master),
        .rd_src_i       (rd_src),
        .ram_rdata_i    (ram_rdata),
        .instr_rvalid_o (instr_rvalid_o),
        .instr_rdata_o  (instr_rdata_o),
        .data_rvalid_o  (data_rvalid_o),
        .data_rdata_o   (data_rdata_o),
        .sb_rvalid_o    (sb_rvalid_o),
        .sb_rdata_o     (sb_rdata_o)
    );

endmodule

/* sim/tb_clk_gen.sv */
/*
 * Testbench clock and reset generator
 * 8 ns clock, active-low reset held for 8 cycles
 */
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;
    end

    initial begin
        rst_no = 1'b0;
        repeat (8) @(posedge clk_o);
        #1 rst_no = 1'b1;
    end

endmodule

/* sim/tb_mm_ram.sv */
/*
 * Testbench of the memory-mapped test memory
 * drives the three masters, models RAM, ROM and status responses and
 * checks grants, rvalid timing, read data, status pulses and the timer irq
 */
`timescale 1ns/1ps
`include "mm_ram_macros.svh"

module tb_mm_ram;

    localparam int M_INSTR = 0;
    localparam int M_DATA  = 1;
    localparam int M_SB    = 2;
    // the tests need about 220 cycles
    localparam int TIMEOUT_CYCLES = 5000;
    localparam int TIMER_N = 10;

    logic        clk, rst_n;
    logic        instr_req_i, instr_gnt_o, instr_rvalid_o;
    logic [31:0] instr_addr_i, instr_rdata_o;
    logic        data_req_i, data_we_i, data_gnt_o, data_rvalid_o;
    logic [3:0]  data_be_i;
    logic [31:0] data_addr_i, data_wdata_i, data_rdata_o;
    logic        sb_req_i, sb_we_i, sb_gnt_o, sb_rvalid_o;
    logic [3:0]  sb_be_i;
    logic [31:0] sb_addr_i, sb_wdata_i, sb_rdata_o;
    logic        irq_ack_i, irq_o, tests_passed_o, tests_failed_o;
    logic [4:0]  irq_id_i, irq_id_o;

    logic [31:0] ref_mem [2 ** (`MM_RAM_AW - 2)];
    logic [31:0] exp_q [$];
    logic [31:0] rand_state = 32'h5929;
    int          cycles = 0;
    logic        instr_gnt_q = 1'b0;
    logic        data_gnt_q = 1'b0;
    logic        sb_gnt_q = 1'b0;
    logic        pass_q = 1'b0;
    logic        fail_q = 1'b0;
    logic        pass_d, fail_d;

    tb_clk_gen u_clk (.clk_o(clk), .rst_no(rst_n));

    mm_ram_top u_dut (
        .clk_i(clk), .rst_ni(rst_n),
        .instr_req_i(instr_req_i), .instr_addr_i(instr_addr_i), .instr_gnt_o(instr_gnt_o),
        .instr_rvalid_o(instr_rvalid_o), .instr_rdata_o(instr_rdata_o),
        .data_req_i(data_req_i), .data_addr_i(data_addr_i), .data_we_i(data_we_i),
        .data_be_i(data_be_i), .data_wdata_i(data_wdata_i), .data_gnt_o(data_gnt_o),
        .data_rvalid_o(data_rvalid_o), .data_rdata_o(data_rdata_o),
        .sb_req_i(sb_req_i), .sb_addr_i(sb_addr_i), .sb_we_i(sb_we_i), .sb_be_i(sb_be_i),
        .sb_wdata_i(sb_wdata_i), .sb_gnt_o(sb_gnt_o), .sb_rvalid_o(sb_rvalid_o),
        .sb_rdata_o(sb_rdata_o), .irq_ack_i(irq_ack_i), .irq_id_i(irq_id_i),
        .irq_o(irq_o), .irq_id_o(irq_id_o),
        .tests_passed_o(tests_passed_o), .tests_failed_o(tests_failed_o)
    );

    task automatic report_failure();
        $display("Checks failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            report_failure();
        end
    endtask

    function logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    function automatic logic in_region(input logic [31:0] addr, input logic [31:0] base,
                                       input logic [31:0] len);
        return (addr >= base) && (addr < base + len);
    endfunction

    // both mirrors of the ram
    function automatic logic is_ram(input logic [31:0] addr);
        return in_region(addr, `MM_SRAM_BASE, `MM_SRAM_LEN) || (addr < `MM_SRAM_LEN);
    endfunction

    function automatic logic [31:0] ref_read(input logic [31:0] addr);
        if (is_ram(addr)) begin
            return ref_mem[addr[`MM_RAM_AW-1:2]];
        end else if (in_region(addr, `MM_ROM_BASE, `MM_ROM_LEN)) begin
            return `MM_BOOT_LOOP_WORD;
        end
        return 32'd0;
    endfunction

    task automatic ref_write(input logic [31:0] addr, input logic [3:0] be,
                             input logic [31:0] wdata);
        if (is_ram(addr)) begin
            for (int i = 0; i < 4; i++) begin
                if (be[i]) begin
                    ref_mem[addr[`MM_RAM_AW-1:2]][8*i +: 8] = wdata[8*i +: 8];
                end
            end
        end
    endtask

    // writes answer with zero and only core writes pulse the status outputs
    task automatic record_access(input int m, input logic [31:0] addr, input logic we,
                                 input logic [3:0] be, input logic [31:0] wdata);
        if (we) begin
            exp_q.push_back(32'd0);
            ref_write(addr, be, wdata);
            if (m == M_DATA && in_region(addr, `MM_CTRL_BASE, `MM_CTRL_LEN)) begin
                pass_d = (wdata == `MM_PASS_VALUE);
                fail_d = (wdata != `MM_PASS_VALUE);
            end
        end else begin
            exp_q.push_back(ref_read(addr));
        end
    endtask

    // sample at the falling edge where all outputs are stable
    always @(negedge clk) begin : monitor
        logic [31:0] resp;
        if (rst_n) begin
            resp = 32'd0;
            if (instr_gnt_q || data_gnt_q || sb_gnt_q) begin
                if (exp_q.size() == 0) begin
                    $display("response at %0t has no expected value", $time);
                    report_failure();
                end else begin
                    resp = exp_q.pop_front();
                end
            end
            compare_value("instr_rvalid_o", instr_rvalid_o, instr_gnt_q);
            compare_value("data_rvalid_o", data_rvalid_o, data_gnt_q);
            compare_value("sb_rvalid_o", sb_rvalid_o, sb_gnt_q);
            compare_value("instr_rdata_o", instr_rdata_o, instr_gnt_q ? resp : 32'd0);
            compare_value("data_rdata_o", data_rdata_o, data_gnt_q ? resp : 32'd0);
            compare_value("sb_rdata_o", sb_rdata_o, sb_gnt_q ? resp : 32'd0);
            compare_value("tests_passed_o", tests_passed_o, pass_q);
            compare_value("tests_failed_o", tests_failed_o, fail_q);

            // fixed priority sb > data > instr
            compare_value("sb_gnt_o", sb_gnt_o, sb_req_i);
            compare_value("data_gnt_o", data_gnt_o, data_req_i && !sb_req_i);
            compare_value("instr_gnt_o", instr_gnt_o,
                          instr_req_i && !sb_req_i && !data_req_i);
            pass_d = 1'b0;
            fail_d = 1'b0;
            if (sb_gnt_o) begin
                record_access(M_SB, sb_addr_i, sb_we_i, sb_be_i, sb_wdata_i);
            end else if (data_gnt_o) begin
                record_access(M_DATA, data_addr_i, data_we_i, data_be_i, data_wdata_i);
            end else if (instr_gnt_o) begin
                record_access(M_INSTR, instr_addr_i, 1'b0, 4'hF, 32'd0);
            end
            instr_gnt_q = instr_gnt_o;
            data_gnt_q  = data_gnt_o;
            sb_gnt_q    = sb_gnt_o;
            pass_q      = pass_d;
            fail_q      = fail_d;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles", cycles);
            report_failure();
        end
    end

    task automatic drive_req(input int m, input logic [31:0] addr, input logic we,
                             input logic [3:0] be, input logic [31:0] wdata);
        case (m)
            M_INSTR: begin
                instr_req_i  = 1'b1;
                instr_addr_i = addr;
            end
            M_DATA: begin
                data_req_i   = 1'b1;
                data_addr_i  = addr;
                data_we_i    = we;
                data_be_i    = be;
                data_wdata_i = wdata;
            end
            default: begin
                sb_req_i   = 1'b1;
                sb_addr_i  = addr;
                sb_we_i    = we;
                sb_be_i    = be;
                sb_wdata_i = wdata;
            end
        endcase
    endtask

    task automatic release_req(input int m);
        case (m)
            M_INSTR: instr_req_i = 1'b0;
            M_DATA:  data_req_i = 1'b0;
            default: sb_req_i = 1'b0;
        endcase
    endtask

    function automatic logic granted(input int m);
        return (m == M_INSTR) ? instr_gnt_o : (m == M_DATA) ? data_gnt_o : sb_gnt_o;
    endfunction

    // returns just after the edge that ends the granted cycle
    task automatic access(input int m, input logic [31:0] addr, input logic we,
                          input logic [3:0] be, input logic [31:0] wdata);
        @(posedge clk);
        #1;
        drive_req(m, addr, we, be, wdata);
        @(negedge clk);
        while (!granted(m)) @(negedge clk);
        @(posedge clk);
        #1;
        release_req(m);
    endtask

    initial begin : stimulus
        logic [31:0] r;
        instr_req_i = 1'b0;
        instr_addr_i = '0;
        data_req_i = 1'b0;
        data_addr_i = '0;
        data_we_i = 1'b0;
        data_be_i = '0;
        data_wdata_i = '0;
        sb_req_i = 1'b0;
        sb_addr_i = '0;
        sb_we_i = 1'b0;
        sb_be_i = '0;
        sb_wdata_i = '0;
        irq_ack_i = 1'b0;
        irq_id_i = '0;
        @(posedge rst_n);

        // random byte-enabled writes over a 16-word window and their read-back
        for (int i = 0; i < 16; i++) begin
            access(M_DATA, 32'h200 + 4 * i, 1'b1, 4'hF, next_rand());
        end
        for (int i = 0; i < 40; i++) begin
            r = next_rand();
            access(M_DATA, (r[24] ? `MM_SRAM_BASE : 32'd0) + 32'h200 + {r[19:16], 2'b00},
                   1'b1, r[3:0], next_rand());
        end
        for (int i = 0; i < 16; i++) begin
            r = next_rand();
            access(M_DATA, (r[0] ? `MM_SRAM_BASE : 32'd0) + 32'h200 + 4 * i,
                   1'b0, 4'hF, 32'd0);
        end

        // sb write at the upper mirror read back at the zero mirror
        access(M_SB, `MM_SRAM_BASE + 32'h400, 1'b1, 4'hF, 32'hCAFE_0001);
        access(M_DATA, 32'h400, 1'b0, 4'hF, 32'd0);
        access(M_INSTR, 32'h400, 1'b0, 4'hF, 32'd0);

        // all three request at once and each drops after its grant
        @(posedge clk);
        #1;
        drive_req(M_SB, `MM_SRAM_BASE + 32'h400, 1'b0, 4'hF, 32'd0);
        drive_req(M_DATA, 32'h200, 1'b0, 4'hF, 32'd0);
        drive_req(M_INSTR, 32'h204, 1'b0, 4'hF, 32'd0);
        @(negedge clk);
        compare_value("sb_gnt_o", sb_gnt_o, 1'b1);
        compare_value("data_gnt_o", data_gnt_o, 1'b0);
        compare_value("instr_gnt_o", instr_gnt_o, 1'b0);
        @(posedge clk);
        #1;
        release_req(M_SB);
        @(negedge clk);
        compare_value("data_gnt_o", data_gnt_o, 1'b1);
        compare_value("instr_gnt_o", instr_gnt_o, 1'b0);
        @(posedge clk);
        #1;
        release_req(M_DATA);
        @(negedge clk);
        compare_value("instr_gnt_o", instr_gnt_o, 1'b1);
        @(posedge clk);
        #1;
        release_req(M_INSTR);

        // rom, unmapped space and a dropped rom write over the low bits of a ram word
        access(M_DATA, `MM_ROM_BASE + 32'h8, 1'b0, 4'hF, 32'd0);
        access(M_INSTR, `MM_ROM_BASE, 1'b0, 4'hF, 32'd0);
        access(M_DATA, 32'h1A11_0000, 1'b0, 4'hF, 32'd0);
        access(M_INSTR, 32'h3000_0000, 1'b0, 4'hF, 32'd0);
        access(M_DATA, `MM_ROM_BASE + 32'h400, 1'b1, 4'hF, 32'h1234_5678);
        access(M_DATA, `MM_ROM_BASE + 32'h400, 1'b0, 4'hF, 32'd0);
        access(M_DATA, 32'h400, 1'b0, 4'hF, 32'd0);

        // status register where the sb write must not pulse
        access(M_DATA, `MM_CTRL_BASE, 1'b1, 4'hF, `MM_PASS_VALUE);
        access(M_DATA, `MM_CTRL_BASE, 1'b1, 4'hF, 32'h0000_0BAD);
        access(M_SB, `MM_CTRL_BASE, 1'b1, 4'hF, `MM_PASS_VALUE);

        // timer with irq 3 unmasked
        access(M_DATA, `MM_TIMER_BASE, 1'b1, 4'hF, 32'h1 << 3);
        access(M_DATA, `MM_TIMER_BASE + 32'h4, 1'b1, 4'hF, TIMER_N);
        for (int k = 0; k <= TIMER_N; k++) begin
            @(negedge clk);
            compare_value("irq_o", irq_o, k == TIMER_N);
        end
        compare_value("irq_id_o", irq_id_o, 5'd3);
        @(posedge clk);
        #1;
        irq_ack_i = 1'b1;
        irq_id_i  = 5'd3;
        @(negedge clk);
        compare_value("irq_o", irq_o, 1'b1);
        @(posedge clk);
        #1;
        irq_ack_i = 1'b0;
        @(negedge clk);
        compare_value("irq_o", irq_o, 1'b0);

        // masked timer runs out silently
        access(M_DATA, `MM_TIMER_BASE, 1'b1, 4'hF, 32'd0);
        access(M_DATA, `MM_TIMER_BASE + 32'h4, 1'b1, 4'hF, 32'd3);
        repeat (8) begin
            @(negedge clk);
            compare_value("irq_o", irq_o, 1'b0);
        end

        repeat (3) @(negedge clk);
        if (exp_q.size() != 0) begin
            $display("%0d expected responses never arrived", exp_q.size());
            report_failure();
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

/* flist.f */
+incdir+.
hw/mm_ram_pkg.sv
hw/bus_arbiter.sv
hw/word_ram.sv
hw/periph_regs.sv
hw/resp_mux.sv
hw/mm_ram_top.sv
sim/tb_clk_gen.sv
sim/tb_mm_ram.sv
